//--- procCore.f
src/procPkg.sv
src/aluUnit.sv
src/instrSequencer.sv
src/controlDecode.sv
src/regFile.sv
src/busDatapath.sv
src/procCore.sv
sim/procCore_assertions.sv
sim/tb_procCore.sv

//--- Bender.yml
package:
  name: procCore

sources:
  - src/procPkg.sv
  - src/aluUnit.sv
  - src/instrSequencer.sv
  - src/controlDecode.sv
  - src/regFile.sv
  - src/busDatapath.sv
  - src/procCore.sv
  - target: simulation
    files:
      - sim/procCore_assertions.sv
      - sim/tb_procCore.sv

//--- sim/tb_procCore.sv
`timescale 1ns/10ps
`default_nettype none

module tb_procCore;

	localparam int DataWidth      = 16;
	localparam int ResetPc        = 10;
	localparam int MemDepth       = 256;
	localparam int ClkPeriod      = 8;
	localparam int ResetCycles    = 16;
	localparam int InstrCount     = 12 + 60 + 16 + 17; // Executed instructions over all tests
	localparam int WatchdogCycles = InstrCount * 8 + 4 * (ResetCycles + 4);

	typedef logic [DataWidth-1:0] wordT;

	logic   Clock = 1'b0;
	logic   rstN;
	wordT   din = '0;
	wordT   addr;
	wordT   dout;
	logic   wren;
	logic   done;

	wordT   mem [MemDepth];
	wordT   prog [$];      // Program image from ResetPc on
	wordT   preAddr [$];   // Data words placed before the run
	wordT   preData [$];
	int     expLen [$];    // Expected cycles per executed instruction
	wordT   expAddr [$];
	wordT   expData [$];
	int     lenLog [$];    // Measured cycles per done pulse
	wordT   wrAddrLog [$];
	wordT   wrDataLog [$];
	int     cycleCount = 0;
	integer seed;

	procCore #(
		.DataWidth(DataWidth),
		.ResetPc  (ResetPc)
	) i_procCore (
		.Clock(Clock),
		.rstN (rstN),
		.din  (din),
		.addr (addr),
		.dout (dout),
		.wren (wren),
		.done (done)
	);

	always #(ClkPeriod / 2) Clock = ~Clock;

	// Synchronous memory with one cycle read latency and a write log
	always @(posedge Clock) begin
		din <= mem[addr[7:0]];
		if (wren) begin
			mem[addr[7:0]] <= dout;
			wrAddrLog.push_back(addr);
			wrDataLog.push_back(dout);
		end
	end

	// Cycles from reset release or the previous done up to each done
	always @(posedge Clock) begin
		if (!rstN) begin
			cycleCount = 0;
		end else begin
			cycleCount++;
			if (done) begin
				lenLog.push_back(cycleCount);
				cycleCount = 0;
			end
		end
	end

	task automatic checkEqual(string name, logic [31:0] actual, logic [31:0] expected);
		if (actual !== expected) begin
			$display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
			$display("Testbench failed");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	function automatic wordT encode(logic [3:0] op, logic [2:0] rx, logic [2:0] ry);
		return wordT'({op, rx, ry}); // Opcode with X and Y in the low 10 bits
	endfunction

	// Instruction length by class
	function automatic int instrCycles(logic [3:0] op);
		case (op)
			procPkg::Mv, procPkg::Mvnz: return 4;
			procPkg::Mvi:               return 7;
			procPkg::Ld, procPkg::Sd:   return 6;
			default:                    return (op <= 4'd5) ? 6 : 4; // ALU or no-op
		endcase
	endfunction

	function automatic wordT aluModel(logic [3:0] op, wordT a, wordT b);
		case (op)
			procPkg::Add: return a + b; // Truncated to the word
			procPkg::Sub: return a - b;
			procPkg::Or:  return a | b;
			procPkg::Slt: return (a < b) ? wordT'(1) : wordT'(0);
			procPkg::Sll: return (b >= wordT'(DataWidth)) ? '0 : a << b[3:0];
			procPkg::Srl: return (b >= wordT'(DataWidth)) ? '0 : a >> b[3:0];
			default:      return '0;
		endcase
	endfunction

	function automatic wordT randWord();
		return wordT'($random(seed));
	endfunction

	task automatic newProgram();
		prog.delete();
		preAddr.delete();
		preData.delete();
		expLen.delete();
		expAddr.delete();
		expData.delete();
	endtask

	// runs is low for words that a jump skips
	task automatic putInstr(logic [3:0] op, logic [2:0] rx, logic [2:0] ry, bit runs);
		prog.push_back(encode(op, rx, ry));
		if (runs) begin
			expLen.push_back(instrCycles(op));
		end
	endtask

	task automatic putMvi(logic [2:0] rx, wordT imm, bit runs);
		putInstr(procPkg::Mvi, rx, 3'd0, runs);
		prog.push_back(imm); // Immediate in the next word
	endtask

	// Points addrReg at target and stores dataReg there
	task automatic storeCheck(logic [2:0] dataReg, logic [2:0] addrReg, wordT target, wordT value);
		putMvi(addrReg, target, 1'b1);
		putInstr(procPkg::Sd, dataReg, addrReg, 1'b1);
		expAddr.push_back(target);
		expData.push_back(value);
	endtask

	task automatic runProgram(string testName);
		@(posedge Clock);
		rstN <= 1'b0;
		@(negedge Clock);
		for (int i = 0; i < MemDepth; i++) begin
			mem[i] <= wordT'({6'(i >> 2), 4'hF, 6'(i)}); // No-op opcode tagged with its address
		end
		foreach (prog[i]) mem[ResetPc + i] <= prog[i];
		foreach (preAddr[i]) mem[preAddr[i][7:0]] <= preData[i];
		repeat (ResetCycles) @(posedge Clock);
		lenLog.delete();
		wrAddrLog.delete();
		wrDataLog.delete();
		rstN <= 1'b1;
		while (lenLog.size() < expLen.size()) @(negedge Clock); // Watchdog guards this
		foreach (expLen[i]) begin
			checkEqual($sformatf("%s cycles of instruction %0d", testName, i), lenLog[i], expLen[i]);
		end
		checkEqual({testName, " write count"}, wrAddrLog.size(), expAddr.size());
		foreach (expAddr[i]) begin
			checkEqual($sformatf("%s addr of write %0d", testName, i), wrAddrLog[i], expAddr[i]);
			checkEqual($sformatf("%s dout of write %0d", testName, i), wrDataLog[i], expData[i]);
		end
	endtask

	task automatic mviStoreTest();
		wordT value;
		newProgram();
		for (int k = 0; k < 4; k++) begin
			value = randWord();
			putMvi(3'(k), value, 1'b1);
			storeCheck(3'(k), 3'(4 + k % 3), wordT'(16'h0080 + 5 * k), value);
		end
		runProgram("mvi/sd");
	endtask

	task automatic aluTest();
		wordT a;
		wordT b;
		newProgram();
		for (int round = 0; round < 2; round++) begin
			for (int op = 0; op < 6; op++) begin
				a = randWord();
				b = randWord();
				if (round == 0 && op >= 4) b = b & 16'h000F; // Shift within the word
				if (round == 1 && op >= 4) b = b | 16'h0010; // Shift past the word
				if (round == 1 && op == 0) a = 16'hFFFF;     // Add wraps
				if (round == 1 && op == 1) a = 16'h0000;     // Sub wraps
				putMvi(3'd2, a, 1'b1);
				putMvi(3'd3, b, 1'b1);
				putInstr(4'(op), 3'd2, 3'd3, 1'b1);
				storeCheck(3'd2, 3'd4, wordT'(16'h00C0 + 6 * round + op), aluModel(4'(op), a, b));
			end
		end
		runProgram("alu");
	endtask

	task automatic loadTest();
		wordT value;
		newProgram();
		for (int k = 0; k < 4; k++) begin
			value = randWord();
			preAddr.push_back(wordT'(16'h00B0 + k));
			preData.push_back(value);
			putMvi(3'd5, wordT'(16'h00B0 + k), 1'b1);
			putInstr(procPkg::Ld, 3'd6, 3'd5, 1'b1);
			storeCheck(3'd6, 3'd1, wordT'(16'h00D0 + k), value); // Loaded word goes back out
		end
		runProgram("ld");
	endtask

	task automatic moveJumpTest();
		wordT v0;
		wordT v1;
		wordT jumpTarget;
		newProgram();
		v0 = randWord();
		v1 = v0 ^ (randWord() | 16'h0001); // Never equal to v0
		putMvi(3'd3, v1, 1'b1);
		putMvi(3'd5, v0, 1'b1);
		putInstr(procPkg::Mvnz, 3'd5, 3'd3, 1'b1); // G still zero from reset
		storeCheck(3'd5, 3'd4, 16'h00E0, v0);
		putMvi(3'd6, 16'h0001, 1'b1);
		putInstr(procPkg::Add, 3'd6, 3'd6, 1'b1);  // G becomes 2
		putInstr(procPkg::Mvnz, 3'd5, 3'd3, 1'b1);
		storeCheck(3'd5, 3'd4, 16'h00E1, v1);
		putInstr(procPkg::Mv, 3'd0, 3'd3, 1'b1);
		storeCheck(3'd0, 3'd4, 16'h00E2, v1);
		// Target lies past this mvi, the mv and the three skipped words
		jumpTarget = wordT'(ResetPc + prog.size() + 6);
		putMvi(3'd1, jumpTarget, 1'b1);
		putInstr(procPkg::Mv, 3'd7, 3'd1, 1'b1);
		putMvi(3'd4, 16'h00E3, 1'b0);
		putInstr(procPkg::Sd, 3'd3, 3'd4, 1'b0);
		storeCheck(3'd3, 3'd4, 16'h00E4, v1);
		runProgram("mv/mvnz");
	endtask

	initial begin
		rstN = 1'b0;
		seed = 32'h1009;
		mviStoreTest();
		aluTest();
		loadTest();
		moveJumpTest();
		@(negedge Clock);
		if (i_procCore.i_procCoreAssertions.failCount == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	// Eight cycles per instruction is above the longest class
	initial begin
		#(WatchdogCycles * ClkPeriod);
		$display("Watchdog expired before all tests finished");
		$display("Testbench failed");
		$fatal(1, "Timeout");
	end

endmodule

`default_nettype wire

//--- sim/procCore_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module procCore_assertions (
	input wire logic Clock,
	input wire logic rstN,
	input wire logic wren,
	input wire logic done
);

	int failCount = 0; // Checked by the testbench at the end

	// Done is a single-cycle pulse
	doneSingle: assert property (@(posedge Clock) disable iff (!rstN) done |=> !done)
		else begin
			failCount++;
			$error("done high in two consecutive cycles");
		end

	// Memory write only in the last step of sd
	wrenWithDone: assert property (@(posedge Clock) disable iff (!rstN) wren |-> done)
		else begin
			failCount++;
			$error("wren high without done");
		end

	// Synchronous reset, outputs idle after each reset edge
	resetQuiet: assert property (@(posedge Clock) !rstN |=> (!wren && !done))
		else begin
			failCount++;
			$error("wren or done high during reset");
		end

endmodule

bind procCore procCore_assertions i_procCoreAssertions (
	.Clock(Clock),
	.rstN (rstN),
	.wren (wren),
	.done (done)
);

`default_nettype wire

//--- src/procCore.sv
`timescale 1ns/10ps
`default_nettype none

module procCore #(
	parameter int DataWidth = 16,
	parameter int ResetPc   = 10
) (
	input  wire logic                 Clock,
	input  wire logic                 rstN,
	input  wire logic [DataWidth-1:0] din,  // Memory read data
	output logic      [DataWidth-1:0] addr, // Memory address
	output logic      [DataWidth-1:0] dout, // Memory write data
	output logic                      wren,
	output logic                      done  // One cycle per finished instruction
);

	procPkg::ctrlT  ctrl;
	procPkg::instrT instr;
	procPkg::stepT  step;

	logic [DataWidth-1:0] bus;
	logic [DataWidth-1:0] rdData;
	logic [DataWidth-1:0] pc;
	logic                 gNonZero;

	// Instruction word needs 10 bits of din
	if (DataWidth < 10) begin : g_widthCheck
		$error("procCore: DataWidth must be at least 10");
	end

	instrSequencer #(
		.DataWidth(DataWidth)
	) i_instrSequencer (
		.Clock(Clock),
		.rstN (rstN),
		.ctrl (ctrl),
		.din  (din),
		.step (step),
		.instr(instr)
	);

	controlDecode i_controlDecode (
		.step    (step),
		.instr   (instr),
		.gNonZero(gNonZero),
		.ctrl    (ctrl)
	);

	regFile #(
		.DataWidth(DataWidth),
		.ResetPc  (ResetPc)
	) i_regFile (
		.Clock (Clock),
		.rstN  (rstN),
		.ctrl  (ctrl),
		.wrData(bus),
		.rdData(rdData),
		.pc    (pc)
	);

	busDatapath #(
		.DataWidth(DataWidth),
		.ResetPc  (ResetPc)
	) i_busDatapath (
		.Clock   (Clock),
		.rstN    (rstN),
		.ctrl    (ctrl),
		.din     (din),
		.rdData  (rdData),
		.pc      (pc),
		.bus     (bus),
		.gNonZero(gNonZero),
		.addr    (addr),
		.dout    (dout),
		.wren    (wren)
	);

	assign done = ctrl.done; // Decoder strobe straight out

endmodule

`default_nettype wire

//--- src/busDatapath.sv
`timescale 1ns/10ps
`default_nettype none

module busDatapath #(
	parameter int DataWidth = 16,
	parameter int ResetPc   = 10
) (
	input  wire logic                 Clock,
	input  wire logic                 rstN,
	input  wire procPkg::ctrlT        ctrl,
	input  wire logic [DataWidth-1:0] din,
	input  wire logic [DataWidth-1:0] rdData,
	input  wire logic [DataWidth-1:0] pc,
	output logic      [DataWidth-1:0] bus,
	output logic                      gNonZero,
	output logic      [DataWidth-1:0] addr,
	output logic      [DataWidth-1:0] dout,
	output logic                      wren
);

	logic [DataWidth-1:0] regA;      // First ALU operand
	logic [DataWidth-1:0] regG;      // ALU result
	logic [DataWidth-1:0] aluResult;

	// Shared bus
	always_comb begin
		case (ctrl.busSrc)
			procPkg::BusG:   bus = regG;
			procPkg::BusDin: bus = din;
			default:         bus = rdData; // Register read port carries the PC for R7
		endcase
	end

	aluUnit #(
		.DataWidth(DataWidth)
	) i_aluUnit (
		.a     (regA),
		.b     (bus),
		.op    (ctrl.aluOp),
		.result(aluResult)
	);

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			regA <= '0;
			regG <= '0;
			addr <= DataWidth'(ResetPc); // Points at first instruction
			wren <= 1'b0;
		end else begin
			if (ctrl.aIn) begin
				regA <= bus;
			end
			if (ctrl.gIn) begin
				regG <= aluResult;
			end
			if (ctrl.addrIn) begin
				addr <= bus;
			end
			wren <= ctrl.wrStrobe; // Single-cycle write strobe
		end
	end

	// Store data toward memory
	always_ff @(posedge Clock) begin
		if (ctrl.doutIn) begin
			dout <= bus;
		end
	end

	assign gNonZero = |regG; // Condition for mvnz

endmodule

`default_nettype wire

//--- src/regFile.sv
`timescale 1ns/10ps
`default_nettype none

module regFile #(
	parameter int DataWidth = 16,
	parameter int ResetPc   = 10
) (
	input  wire logic                 Clock,
	input  wire logic                 rstN,
	input  wire procPkg::ctrlT        ctrl,
	input  wire logic [DataWidth-1:0] wrData, // From the bus
	output logic      [DataWidth-1:0] rdData,
	output logic      [DataWidth-1:0] pc
);

	logic [DataWidth-1:0] regs [8]; // R0 to R6, R7 is the PC
	logic                 pcWrite;  // Bus write to R7 this cycle

	assign pcWrite = ctrl.wrEn && (ctrl.wrSel == procPkg::PcIdx);

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
			regs[procPkg::PcIdx] <= DataWidth'(ResetPc); // Overrides the clear above
		end else begin
			if (ctrl.wrEn) begin
				regs[ctrl.wrSel] <= wrData;
			end
			if (ctrl.pcIncr && !pcWrite) begin
				regs[procPkg::PcIdx] <= regs[procPkg::PcIdx] + 1'b1; // Jump wins over increment
			end
		end
	end

	assign rdData = regs[ctrl.rdSel];
	assign pc     = regs[procPkg::PcIdx];

endmodule

`default_nettype wire

//--- src/controlDecode.sv
`timescale 1ns/10ps
`default_nettype none

module controlDecode (
	input  wire procPkg::stepT  step,
	input  wire procPkg::instrT instr,
	input  wire logic           gNonZero, // G holds a nonzero value
	output procPkg::ctrlT       ctrl
);

	always_comb begin
		ctrl        = '0;              // Everything idle
		ctrl.busSrc = procPkg::BusReg;
		ctrl.aluOp  = procPkg::AluAdd;

		case (step)
			3'd0: begin
				ctrl.rdSel  = procPkg::PcIdx; // PC onto bus
				ctrl.addrIn = 1'b1;           // Fetch address
			end
			3'd1: begin
				// Memory latency, nothing to drive
			end
			3'd2: begin
				ctrl.irIn = 1'b1; // Instruction word is on din
			end
			3'd3: begin
				case (instr.opcode)
					procPkg::Add, procPkg::Sub, procPkg::Or,
					procPkg::Slt, procPkg::Sll, procPkg::Srl: begin
						ctrl.rdSel = instr.rx; // First operand into A
						ctrl.aIn   = 1'b1;
					end
					procPkg::Mv: begin
						ctrl.rdSel  = instr.ry;
						ctrl.wrEn   = 1'b1;
						ctrl.wrSel  = instr.rx;
						ctrl.done   = 1'b1;
						ctrl.pcIncr = 1'b1;
					end
					procPkg::Mvnz: begin
						ctrl.rdSel  = instr.ry;
						ctrl.wrEn   = gNonZero; // Copy only if G != 0
						ctrl.wrSel  = instr.rx;
						ctrl.done   = 1'b1;
						ctrl.pcIncr = 1'b1;
					end
					procPkg::Mvi: begin
						ctrl.pcIncr = 1'b1; // Step over to the immediate word
					end
					procPkg::Ld, procPkg::Sd: begin
						ctrl.rdSel  = instr.ry; // Ry holds the memory address
						ctrl.addrIn = 1'b1;
					end
					default: begin
						ctrl.done = 1'b1; // Unknown opcode, no-op
					end
				endcase
			end
			3'd4: begin
				case (instr.opcode)
					procPkg::Add, procPkg::Sub, procPkg::Or,
					procPkg::Slt, procPkg::Sll, procPkg::Srl: begin
						ctrl.rdSel = instr.ry; // Second operand on bus
						ctrl.gIn   = 1'b1;
						case (instr.opcode)
							procPkg::Sub: ctrl.aluOp = procPkg::AluSub;
							procPkg::Or:  ctrl.aluOp = procPkg::AluOr;
							procPkg::Slt: ctrl.aluOp = procPkg::AluSlt;
							procPkg::Sll: ctrl.aluOp = procPkg::AluSll;
							procPkg::Srl: ctrl.aluOp = procPkg::AluSrl;
							default:      ctrl.aluOp = procPkg::AluAdd;
						endcase
					end
					procPkg::Mvi: begin
						ctrl.rdSel  = procPkg::PcIdx; // Address of immediate
						ctrl.addrIn = 1'b1;
					end
					procPkg::Sd: begin
						ctrl.rdSel    = instr.rx; // Store data
						ctrl.doutIn   = 1'b1;
						ctrl.wrStrobe = 1'b1;     // wren high next cycle
					end
					default: begin
						// Ld waits for memory here
					end
				endcase
			end
			3'd5: begin
				case (instr.opcode)
					procPkg::Add, procPkg::Sub, procPkg::Or,
					procPkg::Slt, procPkg::Sll, procPkg::Srl: begin
						ctrl.busSrc = procPkg::BusG; // Result back to Rx
						ctrl.wrEn   = 1'b1;
						ctrl.wrSel  = instr.rx;
						ctrl.done   = 1'b1;
						ctrl.pcIncr = 1'b1;
					end
					procPkg::Ld: begin
						ctrl.busSrc = procPkg::BusDin; // Loaded word
						ctrl.wrEn   = 1'b1;
						ctrl.wrSel  = instr.rx;
						ctrl.done   = 1'b1;
						ctrl.pcIncr = 1'b1;
					end
					procPkg::Sd: begin
						ctrl.done   = 1'b1; // Memory write happens this cycle
						ctrl.pcIncr = 1'b1;
					end
					default: begin
						// Mvi waits for the immediate
					end
				endcase
			end
			3'd6: begin
				ctrl.done   = 1'b1;
				ctrl.pcIncr = 1'b1;
				if (instr.opcode == procPkg::Mvi) begin
					ctrl.busSrc = procPkg::BusDin; // Immediate into Rx
					ctrl.wrEn   = 1'b1;
					ctrl.wrSel  = instr.rx;
				end
			end
			default: begin
				ctrl.done = 1'b1; // Step 7 never reached, recover anyway
			end
		endcase
	end

endmodule

`default_nettype wire

//--- src/instrSequencer.sv
`timescale 1ns/10ps
`default_nettype none

module instrSequencer #(
	parameter int DataWidth = 16
) (
	input  wire logic                 Clock,
	input  wire logic                 rstN,
	input  wire procPkg::ctrlT        ctrl,
	input  wire logic [DataWidth-1:0] din,
	output procPkg::stepT             step,
	output procPkg::instrT            instr
);

	// Step counter, back to 0 after the done cycle
	always_ff @(posedge Clock) begin
		if (!rstN) begin
			step <= '0;
		end else if (ctrl.done) begin
			step <= '0;
		end else begin
			step <= step + 1'b1; // One step per cycle
		end
	end

	// Instruction register, loaded at end of step 2
	always_ff @(posedge Clock) begin
		if (!rstN) begin
			instr <= '0;
		end else if (ctrl.irIn) begin
			instr <= procPkg::instrT'(din[9:0]); // Upper bits of the word ignored
		end
	end

endmodule

`default_nettype wire

//--- src/aluUnit.sv
`timescale 1ns/10ps
`default_nettype none

module aluUnit #(
	parameter int DataWidth = 16
) (
	input  wire logic [DataWidth-1:0] a,
	input  wire logic [DataWidth-1:0] b,
	input  wire procPkg::aluOpT       op,
	output logic      [DataWidth-1:0] result
);

	always_comb begin
		case (op)
			procPkg::AluAdd: result = a + b; // Wraps modulo 2^DataWidth
			procPkg::AluSub: result = a - b;
			procPkg::AluOr:  result = a | b;
			procPkg::AluSlt: result = DataWidth'(a < b); // Unsigned, 1 or 0
			procPkg::AluSll: result = a << b; // Zero once b >= DataWidth
			procPkg::AluSrl: result = a >> b;
			default:         result = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- src/procPkg.sv
`default_nettype none

package procPkg;

	// Instruction opcodes, IR bits 9 to 6
	typedef enum logic [3:0] {
		Add  = 4'd0,
		Sub  = 4'd1,
		Or   = 4'd2,
		Slt  = 4'd3,
		Sll  = 4'd4,
		Srl  = 4'd5,
		Mv   = 4'd6,
		Mvi  = 4'd7,
		Ld   = 4'd8,
		Sd   = 4'd9,
		Mvnz = 4'd10
	} opcodeT; // Codes 11 to 15 run as no-op

	typedef logic [2:0] regIdxT; // R0 to R7

	localparam regIdxT PcIdx = 3'd7; // R7 doubles as program counter

	// Low 10 bits of an instruction word
	typedef struct packed {
		opcodeT opcode; // Bits 9 to 6
		regIdxT rx;     // Bits 5 to 3, destination / first operand
		regIdxT ry;     // Bits 2 to 0, second operand / address
	} instrT;

	typedef enum logic [2:0] {
		AluAdd = 3'd0,
		AluSub = 3'd1,
		AluOr  = 3'd2,
		AluSlt = 3'd3,
		AluSll = 3'd4,
		AluSrl = 3'd5
	} aluOpT;

	// Who drives the shared bus
	typedef enum logic [1:0] {
		BusReg = 2'd0, // Register file read port
		BusG   = 2'd1, // ALU result register
		BusDin = 2'd2  // Memory read data
	} busSrcT;

	typedef logic [2:0] stepT; // Step inside one instruction

	// Control word, one per cycle
	typedef struct packed {
		busSrcT busSrc;   // Bus driver
		regIdxT rdSel;    // Register read port select
		logic   wrEn;     // Register write from bus
		regIdxT wrSel;    // Register write target
		logic   aIn;      // A loads bus
		logic   gIn;      // G loads ALU result
		aluOpT  aluOp;
		logic   addrIn;   // Addr loads bus
		logic   doutIn;   // Dout loads bus
		logic   wrStrobe; // Memory write in next cycle
		logic   pcIncr;   // PC + 1
		logic   irIn;     // IR loads din
		logic   done;     // Last step of instruction
	} ctrlT;

endpackage

`default_nettype wire
